/* hdl/vec_cache_mshr_pkg.sv */
package vec_cache_mshr_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int MSHR_ENTRY_NUM       = 8;
    localparam int MSHR_ENTRY_IDX_WIDTH = 3;
    localparam int ADDR_WIDTH           = 32;
    localparam int TXNID_WIDTH          = 8;

    typedef logic [MSHR_ENTRY_IDX_WIDTH-1:0] mshr_idx_t;
    typedef logic [ADDR_WIDTH-1:0]           line_addr_t;
    typedef logic [TXNID_WIDTH-1:0]          txnid_t;

    // miss lifecycle of one entry
    typedef enum logic [2:0] {
        MSHR_IDLE      = 3'd0,
        MSHR_MISS_REQ  = 3'd1,
        MSHR_WAIT_FILL = 3'd2,
        MSHR_RD_REQ    = 3'd3,
        MSHR_WAIT_RD   = 3'd4
    } mshr_state_e;

    // update from tag pipe
    typedef struct packed {
        mshr_idx_t  alloc_idx;
        line_addr_t addr;
        txnid_t     txnid;
    } mshr_entry_t;

    // refill request to downstream
    typedef struct packed {
        line_addr_t addr;
        txnid_t     txnid;
        mshr_idx_t  rob_entry_id;
    } downstream_txreq_pld_t;

    // data ram read command
    typedef struct packed {
        line_addr_t addr;
        mshr_idx_t  entry_id;
    } dataram_rd_pld_t;

    // index to one-hot strobe, zero when en is low
    function automatic logic [MSHR_ENTRY_NUM-1:0] idx_onehot(input logic en, input mshr_idx_t idx);
        logic [MSHR_ENTRY_NUM-1:0] vec;
        vec      = '0;
        vec[idx] = en;
        return vec;
    endfunction

endpackage

/* hdl/mshr_dispatch.sv */
module mshr_dispatch
    import vec_cache_mshr_pkg::*;
(
    input  logic                          clk               ,
    input  logic                          rst               ,

    input  logic [MSHR_ENTRY_NUM-1:0]     v_entry_active    ,

    output logic                          alloc_vld         ,
    output mshr_idx_t                     alloc_index       ,
    input  logic                          alloc_rdy         ,

    input  logic                          mshr_update_en    ,
    input  mshr_entry_t                   mshr_update_pld   ,
    input  logic                          linefill_done     ,
    input  mshr_idx_t                     linefill_done_idx ,
    input  logic                          rd_done           ,
    input  mshr_idx_t                     rd_done_idx       ,

    output logic [MSHR_ENTRY_NUM-1:0]     v_update_en       ,
    output logic [MSHR_ENTRY_NUM-1:0]     v_linefill_done   ,
    output logic [MSHR_ENTRY_NUM-1:0]     v_rd_done         ,
    output logic                          mshr_stall
);

    logic [MSHR_ENTRY_NUM-1:0] reserved_q;
    logic [MSHR_ENTRY_NUM-1:0] v_free;
    logic [MSHR_ENTRY_NUM-1:0] v_alloc_take;

    // ------------------------------
    // pre-allocation
    // ------------------------------
    // handed out but not yet written by the tag pipe
    assign v_free = ~v_entry_active & ~reserved_q;

    // lowest free index wins
    always_comb begin
        alloc_index = '0;
        for (int i = MSHR_ENTRY_NUM-1; i >= 0; i--) begin
            if (v_free[i]) begin
                alloc_index = mshr_idx_t'(i);
            end
        end
    end

    assign alloc_vld    = |v_free;
    assign mshr_stall   = ~alloc_vld;
    assign v_alloc_take = idx_onehot(alloc_vld && alloc_rdy, alloc_index);

    // update turns a reserved index into an active entry
    always_ff @(posedge clk) begin
        if (rst) begin
            reserved_q <= '0;
        end else begin
            reserved_q <= (reserved_q & ~v_update_en) | v_alloc_take;
        end
    end

    // ------------------------------
    // strobe decode
    // ------------------------------
    assign v_update_en     = idx_onehot(mshr_update_en, mshr_update_pld.alloc_idx);
    assign v_linefill_done = idx_onehot(linefill_done, linefill_done_idx);
    assign v_rd_done       = idx_onehot(rd_done, rd_done_idx);

endmodule

/* hdl/mshr_entry.sv */
module mshr_entry
    import vec_cache_mshr_pkg::*;
(
    input  logic                    clk           ,
    input  logic                    rst           ,

    input  logic                    update_en     ,
    input  mshr_entry_t             update_pld    ,
    input  logic                    linefill_done ,
    input  logic                    rd_done       ,
    input  mshr_idx_t               entry_id      ,

    output logic                    entry_active  ,

    output logic                    ds_req_vld    ,
    output downstream_txreq_pld_t   ds_req_pld    ,
    input  logic                    ds_req_rdy    ,

    output logic                    rd_req_vld    ,
    output dataram_rd_pld_t         rd_req_pld    ,
    input  logic                    rd_req_rdy    ,

    output logic                    release_en
);

    mshr_state_e state_q;
    mshr_state_e state_d;
    line_addr_t  addr_q;
    txnid_t      txnid_q;

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            MSHR_IDLE: begin
                if (update_en) begin
                    state_d = MSHR_MISS_REQ;
                end
            end
            MSHR_MISS_REQ: begin
                if (ds_req_rdy) begin
                    state_d = MSHR_WAIT_FILL;
                end
            end
            MSHR_WAIT_FILL: begin
                // strobes outside this state are dropped
                if (linefill_done) begin
                    state_d = MSHR_RD_REQ;
                end
            end
            MSHR_RD_REQ: begin
                if (rd_req_rdy) begin
                    state_d = MSHR_WAIT_RD;
                end
            end
            MSHR_WAIT_RD: begin
                if (rd_done) begin
                    state_d = MSHR_IDLE;
                end
            end
            default: begin
                state_d = MSHR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MSHR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line address and txnid of the miss
    always_ff @(posedge clk) begin
        if (update_en && (state_q == MSHR_IDLE)) begin
            addr_q  <= update_pld.addr;
            txnid_q <= update_pld.txnid;
        end
    end

    // ------------------------------
    // requests and release
    // ------------------------------
    assign entry_active = (state_q != MSHR_IDLE);
    assign ds_req_vld   = (state_q == MSHR_MISS_REQ);
    assign rd_req_vld   = (state_q == MSHR_RD_REQ);

    // freed in the same cycle the read completes
    assign release_en   = (state_q == MSHR_WAIT_RD) && rd_done;

    assign ds_req_pld.addr         = addr_q;
    assign ds_req_pld.txnid        = txnid_q;
    assign ds_req_pld.rob_entry_id = entry_id;

    assign rd_req_pld.addr         = addr_q;
    assign rd_req_pld.entry_id     = entry_id;

endmodule

/* hdl/mshr_issue.sv */
module mshr_issue
    import vec_cache_mshr_pkg::*;
(
    input  logic                          clk                       ,
    input  logic                          rst                       ,

    input  logic [MSHR_ENTRY_NUM-1:0]     v_ds_req_vld              ,
    input  downstream_txreq_pld_t         v_ds_req_pld [MSHR_ENTRY_NUM-1:0],
    output logic [MSHR_ENTRY_NUM-1:0]     v_ds_req_rdy              ,
    output logic                          downstream_txreq_vld      ,
    output downstream_txreq_pld_t         downstream_txreq_pld      ,
    input  logic                          downstream_txreq_rdy      ,

    input  logic [MSHR_ENTRY_NUM-1:0]     v_rd_req_vld              ,
    input  dataram_rd_pld_t               v_rd_req_pld [MSHR_ENTRY_NUM-1:0],
    output logic [MSHR_ENTRY_NUM-1:0]     v_rd_req_rdy              ,
    output logic                          dataram_rd_vld            ,
    output dataram_rd_pld_t               dataram_rd_pld            ,
    input  logic                          dataram_rdy               ,

    input  logic [MSHR_ENTRY_NUM-1:0]     v_release_en              ,
    output logic                          entry_release_vld         ,
    output mshr_idx_t                     entry_release_done_index
);

    mshr_idx_t ds_last_q;
    mshr_idx_t ds_hold_idx_q;
    logic      ds_hold_q;
    mshr_idx_t ds_sel;
    logic      ds_xfer;

    mshr_idx_t rd_last_q;
    mshr_idx_t rd_hold_idx_q;
    logic      rd_hold_q;
    mshr_idx_t rd_sel;
    logic      rd_xfer;

    // first requester after the last grant, wrapping
    function automatic mshr_idx_t rr_pick(input logic [MSHR_ENTRY_NUM-1:0] req,
                                          input mshr_idx_t last);
        mshr_idx_t idx;
        mshr_idx_t pick;
        pick = last;
        for (int k = MSHR_ENTRY_NUM; k >= 1; k--) begin
            idx = last + mshr_idx_t'(k);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    // ------------------------------
    // downstream refill request
    // ------------------------------
    // a stalled grant is held so the pld cannot change under back-pressure
    assign ds_sel               = ds_hold_q ? ds_hold_idx_q : rr_pick(v_ds_req_vld, ds_last_q);
    assign downstream_txreq_vld = |v_ds_req_vld;
    assign downstream_txreq_pld = v_ds_req_pld[ds_sel];
    assign ds_xfer              = downstream_txreq_vld && downstream_txreq_rdy;
    assign v_ds_req_rdy         = idx_onehot(ds_xfer, ds_sel);

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_last_q <= mshr_idx_t'(MSHR_ENTRY_NUM-1);
            ds_hold_q <= 1'b0;
        end else begin
            ds_hold_q <= downstream_txreq_vld && !downstream_txreq_rdy;
            if (ds_xfer) begin
                ds_last_q <= ds_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        ds_hold_idx_q <= ds_sel;
    end

    // ------------------------------
    // data ram read
    // ------------------------------
    assign rd_sel         = rd_hold_q ? rd_hold_idx_q : rr_pick(v_rd_req_vld, rd_last_q);
    assign dataram_rd_vld = |v_rd_req_vld;
    assign dataram_rd_pld = v_rd_req_pld[rd_sel];
    assign rd_xfer        = dataram_rd_vld && dataram_rdy;
    assign v_rd_req_rdy   = idx_onehot(rd_xfer, rd_sel);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_last_q <= mshr_idx_t'(MSHR_ENTRY_NUM-1);
            rd_hold_q <= 1'b0;
        end else begin
            rd_hold_q <= dataram_rd_vld && !dataram_rdy;
            if (rd_xfer) begin
                rd_last_q <= rd_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_hold_idx_q <= rd_sel;
    end

    // one-hot release to binary, one rd_done per cycle
    always_comb begin
        entry_release_done_index = '0;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            if (v_release_en[i]) begin
                entry_release_done_index = entry_release_done_index | mshr_idx_t'(i);
            end
        end
    end

    assign entry_release_vld = |v_release_en;

endmodule

/* hdl/vec_cache_mshr.sv */
module vec_cache_mshr
    import vec_cache_mshr_pkg::*;
(
    input  logic                        clk                       ,
    input  logic                        rst                       ,

    // tag pipe
    output logic                        alloc_vld                 ,
    output mshr_idx_t                   alloc_index               ,
    input  logic                        alloc_rdy                 ,
    input  logic                        mshr_update_en            ,
    input  mshr_entry_t                 mshr_update_pld           ,

    // downstream
    output logic                        downstream_txreq_vld      ,
    output downstream_txreq_pld_t       downstream_txreq_pld      ,
    input  logic                        downstream_txreq_rdy      ,

    // data ram
    output logic                        dataram_rd_vld            ,
    output dataram_rd_pld_t             dataram_rd_pld            ,
    input  logic                        dataram_rdy               ,

    input  logic                        linefill_done             ,
    input  mshr_idx_t                   linefill_done_idx         ,
    input  logic                        rd_done                   ,
    input  mshr_idx_t                   rd_done_idx               ,

    output logic                        entry_release_vld         ,
    output mshr_idx_t                   entry_release_done_index  ,
    output logic                        mshr_stall
);

    logic [MSHR_ENTRY_NUM-1:0]  v_entry_active;
    logic [MSHR_ENTRY_NUM-1:0]  v_update_en;
    logic [MSHR_ENTRY_NUM-1:0]  v_linefill_done;
    logic [MSHR_ENTRY_NUM-1:0]  v_rd_done;

    logic [MSHR_ENTRY_NUM-1:0]  v_ds_req_vld;
    downstream_txreq_pld_t      v_ds_req_pld [MSHR_ENTRY_NUM-1:0];
    logic [MSHR_ENTRY_NUM-1:0]  v_ds_req_rdy;

    logic [MSHR_ENTRY_NUM-1:0]  v_rd_req_vld;
    dataram_rd_pld_t            v_rd_req_pld [MSHR_ENTRY_NUM-1:0];
    logic [MSHR_ENTRY_NUM-1:0]  v_rd_req_rdy;

    logic [MSHR_ENTRY_NUM-1:0]  v_release_en;

    mshr_dispatch u_dispatch (
        .clk               (clk               ),
        .rst               (rst               ),
        .v_entry_active    (v_entry_active    ),
        .alloc_vld         (alloc_vld         ),
        .alloc_index       (alloc_index       ),
        .alloc_rdy         (alloc_rdy         ),
        .mshr_update_en    (mshr_update_en    ),
        .mshr_update_pld   (mshr_update_pld   ),
        .linefill_done     (linefill_done     ),
        .linefill_done_idx (linefill_done_idx ),
        .rd_done           (rd_done           ),
        .rd_done_idx       (rd_done_idx       ),
        .v_update_en       (v_update_en       ),
        .v_linefill_done   (v_linefill_done   ),
        .v_rd_done         (v_rd_done         ),
        .mshr_stall        (mshr_stall        ));

    // all entries see the same payload, the strobe picks one
    generate
        for (genvar i = 0; i < MSHR_ENTRY_NUM; i++) begin : MSHR_ENTRY_ARRAY
            mshr_entry u_mshr_entry (
                .clk           (clk                 ),
                .rst           (rst                 ),
                .update_en     (v_update_en[i]      ),
                .update_pld    (mshr_update_pld     ),
                .linefill_done (v_linefill_done[i]  ),
                .rd_done       (v_rd_done[i]        ),
                .entry_id      (mshr_idx_t'(i)      ),
                .entry_active  (v_entry_active[i]   ),
                .ds_req_vld    (v_ds_req_vld[i]     ),
                .ds_req_pld    (v_ds_req_pld[i]     ),
                .ds_req_rdy    (v_ds_req_rdy[i]     ),
                .rd_req_vld    (v_rd_req_vld[i]     ),
                .rd_req_pld    (v_rd_req_pld[i]     ),
                .rd_req_rdy    (v_rd_req_rdy[i]     ),
                .release_en    (v_release_en[i]     ));
        end
    endgenerate

    mshr_issue u_issue (
        .clk                      (clk                      ),
        .rst                      (rst                      ),
        .v_ds_req_vld             (v_ds_req_vld             ),
        .v_ds_req_pld             (v_ds_req_pld             ),
        .v_ds_req_rdy             (v_ds_req_rdy             ),
        .downstream_txreq_vld     (downstream_txreq_vld     ),
        .downstream_txreq_pld     (downstream_txreq_pld     ),
        .downstream_txreq_rdy     (downstream_txreq_rdy     ),
        .v_rd_req_vld             (v_rd_req_vld             ),
        .v_rd_req_pld             (v_rd_req_pld             ),
        .v_rd_req_rdy             (v_rd_req_rdy             ),
        .dataram_rd_vld           (dataram_rd_vld           ),
        .dataram_rd_pld           (dataram_rd_pld           ),
        .dataram_rdy              (dataram_rdy              ),
        .v_release_en             (v_release_en             ),
        .entry_release_vld        (entry_release_vld        ),
        .entry_release_done_index (entry_release_done_index ));

endmodule

/* verification/tb_vec_cache_mshr.sv */
module tb_vec_cache_mshr
    import vec_cache_mshr_pkg::*;
();

    localparam int WAIT_LIMIT = 20;

    logic                  clk;
    logic                  rst;
    logic                  alloc_vld;
    mshr_idx_t             alloc_index;
    logic                  alloc_rdy;
    logic                  mshr_update_en;
    mshr_entry_t           mshr_update_pld;
    logic                  downstream_txreq_vld;
    downstream_txreq_pld_t downstream_txreq_pld;
    logic                  downstream_txreq_rdy;
    logic                  dataram_rd_vld;
    dataram_rd_pld_t       dataram_rd_pld;
    logic                  dataram_rdy;
    logic                  linefill_done;
    mshr_idx_t             linefill_done_idx;
    logic                  rd_done;
    mshr_idx_t             rd_done_idx;
    logic                  entry_release_vld;
    mshr_idx_t             entry_release_done_index;
    logic                  mshr_stall;

    // reference model of the entries
    mshr_state_e               ref_state [MSHR_ENTRY_NUM];
    line_addr_t                ref_addr [MSHR_ENTRY_NUM];
    txnid_t                    ref_txnid [MSHR_ENTRY_NUM];
    logic [MSHR_ENTRY_NUM-1:0] ref_reserved;
    mshr_idx_t                 ds_last;
    mshr_idx_t                 rd_last;
    mshr_idx_t                 ds_offer;
    mshr_idx_t                 rd_offer;
    logic                      ds_offer_vld;
    logic                      rd_offer_vld;
    mshr_idx_t                 order_q [MSHR_ENTRY_NUM];

    int err_cnt;
    int test_err;
    int check_cnt;
    int test_cnt;

    vec_cache_mshr vec_cache_mshr_i (.*);

    always #5 clk = ~clk;

    // ------------------------------
    // checking helpers
    // ------------------------------
    task automatic note_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            note_error();
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %s done with %0d errors", name, test_err);
        test_err = 0;
    endtask

    function automatic logic watched_valid(input int which);
        case (which)
            0: return alloc_vld;
            1: return downstream_txreq_vld;
            default: return dataram_rd_vld;
        endcase
    endfunction

    // ends on the negedge where the valid is seen
    task automatic wait_high(input int which, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!watched_valid(which) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!watched_valid(which)) begin
            $display("timeout: %s did not rise within %0d cycles", what, WAIT_LIMIT);
            note_error();
        end
    endtask

    // ------------------------------
    // model queries
    // ------------------------------
    function automatic int lowest_free();
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            if (ref_state[i] == MSHR_IDLE && !ref_reserved[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int count_state(input mshr_state_e st);
        int n;
        n = 0;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            if (ref_state[i] == st) begin
                n++;
            end
        end
        return n;
    endfunction

    // next entry in state st after last, wrapping
    function automatic mshr_idx_t next_after(input mshr_idx_t last, input mshr_state_e st);
        mshr_idx_t idx;
        for (int k = 1; k <= MSHR_ENTRY_NUM; k++) begin
            idx = mshr_idx_t'((int'(last) + k) % MSHR_ENTRY_NUM);
            if (ref_state[idx] == st) begin
                return idx;
            end
        end
        return last;
    endfunction

    // an offer is fixed when its valid rises and only moves on a transfer
    task automatic refresh_offers();
        if (!ds_offer_vld && count_state(MSHR_MISS_REQ) > 0) begin
            ds_offer     = next_after(ds_last, MSHR_MISS_REQ);
            ds_offer_vld = 1'b1;
        end
        if (!rd_offer_vld && count_state(MSHR_RD_REQ) > 0) begin
            rd_offer     = next_after(rd_last, MSHR_RD_REQ);
            rd_offer_vld = 1'b1;
        end
    endtask

    // ------------------------------
    // bus actions
    // ------------------------------
    task automatic alloc_entry(output mshr_idx_t idx);
        int exp_idx;
        exp_idx = lowest_free();
        idx     = mshr_idx_t'(exp_idx);
        @(posedge clk);
        alloc_rdy <= 1'b1;
        wait_high(0, "alloc_vld");
        check_value("alloc_index", alloc_index, exp_idx);
        @(posedge clk);
        alloc_rdy <= 1'b0;
        ref_reserved[idx] = 1'b1;
    endtask

    task automatic update_entry(input mshr_idx_t idx, input line_addr_t line,
                                input txnid_t txn);
        @(posedge clk);
        mshr_update_en  <= 1'b1;
        mshr_update_pld <= '{alloc_idx: idx, addr: line, txnid: txn};
        @(posedge clk);
        mshr_update_en <= 1'b0;
        ref_reserved[idx] = 1'b0;
        ref_state[idx]    = MSHR_MISS_REQ;
        ref_addr[idx]     = line;
        ref_txnid[idx]    = txn;
        refresh_offers();
    endtask

    task automatic accept_downstream(output mshr_idx_t got);
        @(posedge clk);
        downstream_txreq_rdy <= 1'b1;
        wait_high(1, "downstream_txreq_vld");
        got = downstream_txreq_pld.rob_entry_id;
        check_value("downstream_txreq_pld.rob_entry_id", got, ds_offer);
        check_value("downstream_txreq_pld.addr", downstream_txreq_pld.addr,
                    ref_addr[ds_offer]);
        check_value("downstream_txreq_pld.txnid", downstream_txreq_pld.txnid,
                    ref_txnid[ds_offer]);
        @(posedge clk);
        downstream_txreq_rdy <= 1'b0;
        ref_state[ds_offer] = MSHR_WAIT_FILL;
        ds_last             = ds_offer;
        ds_offer_vld        = 1'b0;
        refresh_offers();
    endtask

    task automatic accept_read(output mshr_idx_t got);
        @(posedge clk);
        dataram_rdy <= 1'b1;
        wait_high(2, "dataram_rd_vld");
        got = dataram_rd_pld.entry_id;
        check_value("dataram_rd_pld.entry_id", got, rd_offer);
        check_value("dataram_rd_pld.addr", dataram_rd_pld.addr, ref_addr[rd_offer]);
        @(posedge clk);
        dataram_rdy <= 1'b0;
        ref_state[rd_offer] = MSHR_WAIT_RD;
        rd_last             = rd_offer;
        rd_offer_vld        = 1'b0;
        refresh_offers();
    endtask

    task automatic pulse_linefill(input mshr_idx_t idx);
        @(posedge clk);
        linefill_done     <= 1'b1;
        linefill_done_idx <= idx;
        @(posedge clk);
        linefill_done <= 1'b0;
        if (ref_state[idx] == MSHR_WAIT_FILL) begin
            ref_state[idx] = MSHR_RD_REQ;
        end
        refresh_offers();
    endtask

    // release is visible in the same cycle as rd_done
    task automatic complete_read(input mshr_idx_t idx);
        @(posedge clk);
        rd_done     <= 1'b1;
        rd_done_idx <= idx;
        @(negedge clk);
        check_value("entry_release_vld", entry_release_vld, ref_state[idx] == MSHR_WAIT_RD);
        check_value("entry_release_done_index", entry_release_done_index, idx);
        @(posedge clk);
        rd_done <= 1'b0;
        if (ref_state[idx] == MSHR_WAIT_RD) begin
            ref_state[idx] = MSHR_IDLE;
        end
    endtask

    task automatic shuffle_order();
        int        j;
        mshr_idx_t tmp;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            order_q[i] = mshr_idx_t'(i);
        end
        for (int i = MSHR_ENTRY_NUM-1; i > 0; i--) begin
            j          = $urandom % (i + 1);
            tmp        = order_q[i];
            order_q[i] = order_q[j];
            order_q[j] = tmp;
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic reset_values();
        @(negedge clk);
        check_value("alloc_vld", alloc_vld, 1'b1);
        check_value("alloc_index", alloc_index, 0);
        check_value("downstream_txreq_vld", downstream_txreq_vld, 1'b0);
        check_value("dataram_rd_vld", dataram_rd_vld, 1'b0);
        check_value("entry_release_vld", entry_release_vld, 1'b0);
        check_value("mshr_stall", mshr_stall, 1'b0);
        finish_test("reset_values");
    endtask

    task automatic single_miss_flow();
        mshr_idx_t idx;
        mshr_idx_t got;
        alloc_entry(idx);
        update_entry(idx, line_addr_t'($urandom()), txnid_t'($urandom()));
        accept_downstream(got);
        pulse_linefill(idx);
        accept_read(got);
        complete_read(idx);
        @(negedge clk);
        check_value("alloc_index", alloc_index, lowest_free());
        finish_test("single_miss_flow");
    endtask

    task automatic fill_all_entries();
        mshr_idx_t idx;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            alloc_entry(idx);
            update_entry(idx, line_addr_t'($urandom()), txnid_t'($urandom()));
        end
        @(negedge clk);
        check_value("mshr_stall", mshr_stall, 1'b1);
        check_value("alloc_vld", alloc_vld, 1'b0);
        finish_test("fill_all_entries");
    endtask

    task automatic backpressure_order();
        logic [MSHR_ENTRY_NUM-1:0] seen;
        mshr_idx_t                 got;
        int                        hold_cycles;
        int                        n_pending;
        hold_cycles = 2 + ($urandom % 8);
        repeat (hold_cycles) begin
            @(negedge clk);
            check_value("downstream_txreq_vld", downstream_txreq_vld, 1'b1);
            check_value("downstream_txreq_pld.rob_entry_id",
                        downstream_txreq_pld.rob_entry_id, ds_offer);
            check_value("downstream_txreq_pld.addr", downstream_txreq_pld.addr,
                        ref_addr[ds_offer]);
            check_value("downstream_txreq_pld.txnid", downstream_txreq_pld.txnid,
                        ref_txnid[ds_offer]);
        end
        seen      = '0;
        n_pending = count_state(MSHR_MISS_REQ);
        for (int n = 0; n < n_pending; n++) begin
            accept_downstream(got);
            if (seen[got]) begin
                $display("entry %0d was granted downstream more than once", got);
                note_error();
            end
            seen[got] = 1'b1;
        end
        check_value("granted entries", seen, {MSHR_ENTRY_NUM{1'b1}});
        @(negedge clk);
        check_value("downstream_txreq_vld", downstream_txreq_vld, 1'b0);
        finish_test("backpressure_order");
    endtask

    task automatic random_completion();
        mshr_idx_t got;
        int        n_reads;
        shuffle_order();
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            pulse_linefill(order_q[i]);
        end
        n_reads = count_state(MSHR_RD_REQ);
        for (int n = 0; n < n_reads; n++) begin
            accept_read(got);
        end
        shuffle_order();
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            complete_read(order_q[i]);
            @(negedge clk);
            check_value("alloc_vld", alloc_vld, 1'b1);
            check_value("alloc_index", alloc_index, lowest_free());
        end
        // every entry is idle here, so the strobe must be dropped
        pulse_linefill(mshr_idx_t'($urandom()));
        repeat (2) begin
            @(negedge clk);
            check_value("dataram_rd_vld", dataram_rd_vld, 1'b0);
        end
        finish_test("random_completion");
    endtask

    initial begin
        void'($urandom(32'h7c70));
        clk                  = 1'b0;
        rst                  = 1'b1;
        alloc_rdy            = 1'b0;
        mshr_update_en       = 1'b0;
        mshr_update_pld      = '0;
        downstream_txreq_rdy = 1'b0;
        dataram_rdy          = 1'b0;
        linefill_done        = 1'b0;
        linefill_done_idx    = '0;
        rd_done              = 1'b0;
        rd_done_idx          = '0;
        for (int i = 0; i < MSHR_ENTRY_NUM; i++) begin
            ref_state[i] = MSHR_IDLE;
            ref_addr[i]  = '0;
            ref_txnid[i] = '0;
        end
        ref_reserved = '0;
        ds_last      = mshr_idx_t'(MSHR_ENTRY_NUM-1);
        rd_last      = mshr_idx_t'(MSHR_ENTRY_NUM-1);
        ds_offer     = '0;
        rd_offer     = '0;
        ds_offer_vld = 1'b0;
        rd_offer_vld = 1'b0;
        err_cnt      = 0;
        test_err     = 0;
        check_cnt    = 0;
        test_cnt     = 0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        single_miss_flow();
        fill_all_entries();
        backpressure_order();
        random_completion();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/vec_cache_mshr_pkg.sv
hdl/mshr_dispatch.sv
hdl/mshr_entry.sv
hdl/mshr_issue.sv
hdl/vec_cache_mshr.sv
verification/tb_vec_cache_mshr.sv

/* Bender.yml */
package:
  name: vec_cache_mshr

sources:
  - hdl/vec_cache_mshr_pkg.sv
  - hdl/mshr_dispatch.sv
  - hdl/mshr_entry.sv
  - hdl/mshr_issue.sv
  - hdl/vec_cache_mshr.sv
  - target: test
    files:
      - verification/tb_vec_cache_mshr.sv
